// File: include/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// Data memory depth in 32-bit words
`define MIPS_DM_WORDS 1024

// Data path width
`define MIPS_XLEN 32

// ALU operand pairs chosen by decode
`define MIPS_SRC_RS_RT    2'd0
`define MIPS_SRC_RS_IMM   2'd1
`define MIPS_SRC_RT_SHAMT 2'd2

`endif

// File: hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBlez    = 6'h06,
        opBgtz    = 6'h07,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLb      = 6'h20,
        opLh      = 6'h21,
        opLw      = 6'h23,
        opSb      = 6'h28,
        opSh      = 6'h29,
        opSw      = 6'h2b
    } opCode;

    // SPECIAL function field
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25
    } functCode;

    typedef struct packed {
        opCode      op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functCode   funct;
    } rFields;

    typedef struct packed {
        opCode       op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFields;

    typedef struct packed {
        opCode       op;
        logic [25:0] index26;
    } jFields;

    // One fetched word, viewed in all three formats
    typedef union packed {
        rFields r;
        iFields i;
        jFields j;
    } instrWord;

    //////////////////////////////////////////////////
    // Control encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSll} aluOp;
    typedef enum logic [2:0] {cmpNone, cmpEq, cmpNe, cmpLez, cmpGtz} cmpOp;
    typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcJumpReg} npcOp;
    typedef enum logic [1:0] {memWord, memHalf, memByte} memSize;
    typedef enum logic [1:0] {wbAlu, wbMem, wbLink, wbUpper} wbSel;

endpackage

`default_nettype wire

// File: hdl/decodeBus.sv
`default_nettype none
`timescale 1ns/100ps
`include "mips_defs.svh"

interface decodeBus import mipsPkg::*; ();

    // Operands
    logic [`MIPS_XLEN-1:0] rsData;
    logic [`MIPS_XLEN-1:0] rtData;
    logic [`MIPS_XLEN-1:0] extImm;
    logic [4:0]            shamt;

    // Execute and memory control
    aluOp       aluCtrl;
    logic [1:0] srcSel;
    cmpOp       cmpCtrl;
    logic       memWrite;
    logic       memRead;
    memSize     memSz;
    logic       memSigned;
    wbSel       wbSelect;

    modport producer (
        output rsData, rtData, extImm, shamt,
        output aluCtrl, srcSel, cmpCtrl,
        output memWrite, memRead, memSz, memSigned,
        output wbSelect
    );

    modport consumer (
        input rsData, rtData, extImm, shamt,
        input aluCtrl, srcSel, cmpCtrl,
        input memWrite, memRead, memSz, memSigned,
        input wbSelect
    );

endinterface

`default_nettype wire

// File: hdl/fetchStage.sv
`default_nettype none
`timescale 1ns/100ps
`include "mips_defs.svh"

module fetchStage import mipsPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  npcOp                  npcSel,
    input  logic                  branchTaken,
    input  logic [25:0]           index,
    input  logic [15:0]           offset,
    input  logic [`MIPS_XLEN-1:0] rsData,
    output logic [`MIPS_XLEN-1:0] pc
);

    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] branchTarget;
    logic [`MIPS_XLEN-1:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{offset[15]}}, offset, 2'b00};

    always_comb begin
        case (npcSel)
            npcBranch:  nextPc = branchTaken ? branchTarget : pcPlus4;
            // Stay inside the current 256 MB region
            npcJump:    nextPc = {pc[31:28], index, 2'b00};
            npcJumpReg: nextPc = rsData;
            default:    nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // A jr through a misaligned register would break instruction fetch
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`default_nettype none
`timescale 1ns/100ps
`include "mips_defs.svh"

module decodeStage import mipsPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  instrWord              instr,
    input  logic [`MIPS_XLEN-1:0] wbData,
    decodeBus.producer            bus,
    output npcOp                  npcSel,
    output logic [25:0]           index,
    output logic [15:0]           offset,
    output logic                  regWrite,
    output logic [4:0]            regAddr
);

    localparam logic [1:0] dstRt   = 2'd0;
    localparam logic [1:0] dstRd   = 2'd1;
    localparam logic [1:0] dstLink = 2'd2;

    logic                  legal;
    logic                  regWe;
    logic                  extSigned;
    logic [1:0]            dstSel;
    logic [`MIPS_XLEN-1:0] regFile [32];

    //////////////////////////////////////////////////
    // Control decoder
    //////////////////////////////////////////////////

    always_comb begin
        legal         = 1'b1;
        regWe         = 1'b0;
        extSigned     = 1'b0;
        dstSel        = dstRt;
        npcSel        = npcSeq;
        bus.aluCtrl   = aluAdd;
        bus.srcSel    = `MIPS_SRC_RS_RT;
        bus.cmpCtrl   = cmpNone;
        bus.memWrite  = 1'b0;
        bus.memRead   = 1'b0;
        bus.memSz     = memWord;
        bus.memSigned = 1'b0;
        bus.wbSelect  = wbAlu;
        case (instr.r.op)
            opSpecial: begin
                dstSel = dstRd;
                regWe  = 1'b1;
                case (instr.r.funct)
                    fnAddu: bus.aluCtrl = aluAdd;
                    fnSubu: bus.aluCtrl = aluSub;
                    fnAnd:  bus.aluCtrl = aluAnd;
                    fnOr:   bus.aluCtrl = aluOr;
                    fnSll: begin
                        bus.aluCtrl = aluSll;
                        bus.srcSel  = `MIPS_SRC_RT_SHAMT;
                    end
                    fnJr: begin
                        regWe  = 1'b0;
                        npcSel = npcJumpReg;
                    end
                    default: begin
                        regWe = 1'b0;
                        legal = 1'b0;
                    end
                endcase
            end
            opOri: begin
                regWe       = 1'b1;
                bus.aluCtrl = aluOr;
                bus.srcSel  = `MIPS_SRC_RS_IMM;
            end
            opLui: begin
                regWe        = 1'b1;
                bus.wbSelect = wbUpper;
            end
            opLw, opLh, opLb: begin
                regWe         = 1'b1;
                extSigned     = 1'b1;
                bus.srcSel    = `MIPS_SRC_RS_IMM;
                bus.memRead   = 1'b1;
                bus.memSigned = 1'b1;
                bus.wbSelect  = wbMem;
                bus.memSz     = (instr.i.op == opLw) ? memWord :
                                (instr.i.op == opLh) ? memHalf : memByte;
            end
            opSw, opSh, opSb: begin
                extSigned    = 1'b1;
                bus.srcSel   = `MIPS_SRC_RS_IMM;
                bus.memWrite = 1'b1;
                bus.memSz    = (instr.i.op == opSw) ? memWord :
                               (instr.i.op == opSh) ? memHalf : memByte;
            end
            opBeq: begin
                npcSel      = npcBranch;
                bus.cmpCtrl = cmpEq;
            end
            opBne: begin
                npcSel      = npcBranch;
                bus.cmpCtrl = cmpNe;
            end
            opBlez: begin
                npcSel      = npcBranch;
                bus.cmpCtrl = cmpLez;
            end
            opBgtz: begin
                npcSel      = npcBranch;
                bus.cmpCtrl = cmpGtz;
            end
            opJ:    npcSel = npcJump;
            opJal: begin
                npcSel       = npcJump;
                regWe        = 1'b1;
                dstSel       = dstLink;
                bus.wbSelect = wbLink;
            end
            default: legal = 1'b0;
        endcase
    end

    // Destination register select
    assign regAddr  = (dstSel == dstRd)   ? instr.r.rd :
                      (dstSel == dstLink) ? 5'd31 : instr.r.rt;

    // No write to r0 and none while in reset
    assign regWrite = regWe && (regAddr != 5'd0) && !reset;

    assign index      = instr.j.index26;
    assign offset     = instr.i.imm16;
    assign bus.shamt  = instr.r.shamt;
    assign bus.extImm = extSigned ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
                                  : {16'b0, instr.i.imm16};

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    assign bus.rsData = (instr.r.rs == 5'd0) ? '0 : regFile[instr.r.rs];
    assign bus.rtData = (instr.r.rt == 5'd0) ? '0 : regFile[instr.r.rt];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regFile[k] <= '0;
            end
        end else if (regWrite) begin
            regFile[regAddr] <= wbData;
        end
    end

    // Fetched words must decode to a supported instruction
    legalOpcode: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(instr) |-> legal)
        else $error("Unsupported instruction %h", instr);

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`default_nettype none
`timescale 1ns/100ps
`include "mips_defs.svh"

module executeStage import mipsPkg::*; (
    decodeBus.consumer            bus,
    output logic [`MIPS_XLEN-1:0] aluResult,
    output logic                  branchTaken
);

    logic [`MIPS_XLEN-1:0] srcA;
    logic [`MIPS_XLEN-1:0] srcB;
    logic                  rsZero;

    // Shifts take rt as the value and shamt as the amount
    assign srcA = (bus.srcSel == `MIPS_SRC_RT_SHAMT) ? bus.rtData : bus.rsData;

    always_comb begin
        case (bus.srcSel)
            `MIPS_SRC_RS_IMM:   srcB = bus.extImm;
            `MIPS_SRC_RT_SHAMT: srcB = {27'b0, bus.shamt};
            default:            srcB = bus.rtData;
        endcase
    end

    always_comb begin
        case (bus.aluCtrl)
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluSll:  aluResult = srcA << srcB[4:0];
            default: aluResult = srcA + srcB;
        endcase
    end

    //////////////////////////////////////////////////
    // Branch condition
    //////////////////////////////////////////////////

    assign rsZero = (bus.rsData == '0);

    always_comb begin
        case (bus.cmpCtrl)
            cmpEq:   branchTaken = (bus.rsData == bus.rtData);
            cmpNe:   branchTaken = (bus.rsData != bus.rtData);
            cmpLez:  branchTaken = bus.rsData[31] || rsZero;
            cmpGtz:  branchTaken = !bus.rsData[31] && !rsZero;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/memoryStage.sv
`default_nettype none
`timescale 1ns/100ps
`include "mips_defs.svh"

module memoryStage import mipsPkg::*; (
    input  logic                  clk,
    decodeBus.consumer            bus,
    input  logic [`MIPS_XLEN-1:0] aluResult,
    input  logic [`MIPS_XLEN-1:0] pc,
    output logic [`MIPS_XLEN-1:0] wbData
);

    localparam int addrBits = $clog2(`MIPS_DM_WORDS);

    logic [`MIPS_XLEN-1:0] dataMem [`MIPS_DM_WORDS];
    logic [addrBits-1:0]   wordAddr;
    logic [3:0]            byteEn;
    logic [`MIPS_XLEN-1:0] storeData;
    logic [`MIPS_XLEN-1:0] readWord;
    logic [15:0]           halfLane;
    logic [7:0]            byteLane;
    logic [`MIPS_XLEN-1:0] loadData;

    assign wordAddr = aluResult[addrBits+1:2];

    //////////////////////////////////////////////////
    // Stores
    //////////////////////////////////////////////////

    // Replicate the store value into every lane, byteEn picks the lane
    always_comb begin
        case (bus.memSz)
            memHalf: begin
                byteEn    = aluResult[1] ? 4'b1100 : 4'b0011;
                storeData = {2{bus.rtData[15:0]}};
            end
            memByte: begin
                byteEn    = 4'b0001 << aluResult[1:0];
                storeData = {4{bus.rtData[7:0]}};
            end
            default: begin
                byteEn    = 4'b1111;
                storeData = bus.rtData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    dataMem[wordAddr][8*b +: 8] <= storeData[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Loads and write-back
    //////////////////////////////////////////////////

    assign readWord = dataMem[wordAddr];
    assign halfLane = aluResult[1] ? readWord[31:16] : readWord[15:0];
    assign byteLane = readWord[8*aluResult[1:0] +: 8];

    always_comb begin
        loadData = '0;
        if (bus.memRead) begin
            case (bus.memSz)
                memHalf: loadData = {{16{bus.memSigned & halfLane[15]}}, halfLane};
                memByte: loadData = {{24{bus.memSigned & byteLane[7]}}, byteLane};
                default: loadData = readWord;
            endcase
        end
    end

    always_comb begin
        case (bus.wbSelect)
            wbMem:   wbData = loadData;
            wbLink:  wbData = pc + 32'd4;
            wbUpper: wbData = {bus.extImm[15:0], 16'b0};
            default: wbData = aluResult;
        endcase
    end

    // Address comes from execute, size from decode
    accessAligned: assert property (@(posedge clk)
        (bus.memRead || bus.memWrite) |->
            ((bus.memSz == memHalf) -> !aluResult[0]) &&
            ((bus.memSz == memWord) -> (aluResult[1:0] == 2'b00)))
        else $error("Misaligned data access at %h", aluResult);

endmodule

`default_nettype wire

// File: hdl/mipsCore.sv
`default_nettype none
`timescale 1ns/100ps
`include "mips_defs.svh"

module mipsCore import mipsPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`MIPS_XLEN-1:0] instrAddr,
    input  logic [`MIPS_XLEN-1:0] instr,
    output logic                  regWrite,
    output logic [4:0]            regAddr,
    output logic [`MIPS_XLEN-1:0] regData
);

    npcOp                  npcSel;
    logic                  branchTaken;
    logic [25:0]           index;
    logic [15:0]           offset;
    logic [`MIPS_XLEN-1:0] aluResult;

    decodeBus dBus ();

    fetchStage i_fetchStage (
        .clk         (clk),
        .reset       (reset),
        .npcSel      (npcSel),
        .branchTaken (branchTaken),
        .index       (index),
        .offset      (offset),
        .rsData      (dBus.rsData),
        .pc          (instrAddr)
    );

    // regData doubles as the register file write data
    decodeStage i_decodeStage (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .wbData   (regData),
        .bus      (dBus.producer),
        .npcSel   (npcSel),
        .index    (index),
        .offset   (offset),
        .regWrite (regWrite),
        .regAddr  (regAddr)
    );

    executeStage i_executeStage (
        .bus         (dBus.consumer),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    memoryStage i_memoryStage (
        .clk       (clk),
        .bus       (dBus.consumer),
        .aluResult (aluResult),
        .pc        (instrAddr),
        .wbData    (regData)
    );

endmodule

`default_nettype wire

// File: dv/mipsCoreTb.sv
`default_nettype none
`timescale 1ns/100ps

module mipsCoreTb;

    localparam int clkPeriod = 20;
    localparam int progWords = 64;
    localparam logic [31:0] resetPc = 32'h0000_3000;

    // Opcodes
    localparam int opSpecial = 'h00;
    localparam int opJ       = 'h02;
    localparam int opJal     = 'h03;
    localparam int opBeq     = 'h04;
    localparam int opBne     = 'h05;
    localparam int opBlez    = 'h06;
    localparam int opBgtz    = 'h07;
    localparam int opOri     = 'h0d;
    localparam int opLui     = 'h0f;
    localparam int opLb      = 'h20;
    localparam int opLh      = 'h21;
    localparam int opLw      = 'h23;
    localparam int opSb      = 'h28;
    localparam int opSh      = 'h29;
    localparam int opSw      = 'h2b;

    // SPECIAL function codes
    localparam int fnSll  = 'h00;
    localparam int fnJr   = 'h08;
    localparam int fnAddu = 'h21;
    localparam int fnSubu = 'h23;
    localparam int fnAnd  = 'h24;
    localparam int fnOr   = 'h25;

    logic        clk;
    logic        reset;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic        regWrite;
    logic [4:0]  regAddr;
    logic [31:0] regData;

    logic [31:0] progMem [progWords];
    logic [31:0] expAddr [$];
    logic        expWrite [$];
    logic [4:0]  expReg [$];
    logic [31:0] expData [$];
    int          errors = 0;
    int          rowCount = 0;

    mipsCore i_mipsCore (
        .clk       (clk),
        .reset     (reset),
        .instrAddr (instrAddr),
        .instr     (instr),
        .regWrite  (regWrite),
        .regAddr   (regAddr),
        .regData   (regData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////

    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input int shamt, input int funct);
        return {opSpecial[5:0], rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
    endfunction

    function automatic logic [31:0] iType(input int op, input int rs, input int rt,
                                          input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // Target is a byte address
    function automatic logic [31:0] jType(input int op, input int target);
        return {op[5:0], target[27:2]};
    endfunction

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] offset;
        logic [31:0] word;
        offset = addr - resetPc;
        if (offset[1:0] != 2'b00 || offset >= 32'(progWords * 4)) begin
            word = 32'h0;
        end else begin
            word = progMem[offset[7:2]];
        end
        return word;
    endfunction

    //////////////////////////////////////////////////
    // Program and expected retire trace
    //////////////////////////////////////////////////

    task automatic loadProgram();
        for (int k = 0; k < progWords; k++) begin
            // Skipped slots write r20 with a tag of their slot number
            progMem[k] = iType(opOri, 0, 20, int'(16'hd000 | 16'(k)));
        end
        progMem[0]  = rType(0, 0, 0, 0, fnSll);
        progMem[1]  = iType(opOri, 0, 1, 'h1234);
        progMem[2]  = iType(opLui, 0, 2, 'h8765);
        progMem[3]  = iType(opOri, 2, 2, 'h4321);
        progMem[4]  = rType(1, 2, 3, 0, fnAddu);
        progMem[5]  = rType(2, 1, 4, 0, fnSubu);
        progMem[6]  = rType(2, 3, 5, 0, fnAnd);
        progMem[7]  = rType(1, 2, 6, 0, fnOr);
        progMem[8]  = rType(0, 1, 7, 4, fnSll);
        progMem[9]  = iType(opOri, 1, 0, 'hffff);
        progMem[10] = rType(0, 1, 8, 0, fnAddu);
        // Data base address in r9
        progMem[11] = iType(opOri, 0, 9, 'h0100);
        progMem[12] = iType(opSw, 9, 2, 0);
        progMem[13] = iType(opLw, 9, 10, 0);
        progMem[14] = iType(opSw, 9, 0, 4);
        progMem[15] = iType(opSb, 9, 2, 4);
        progMem[16] = iType(opOri, 0, 11, 'h80ff);
        progMem[17] = iType(opSh, 9, 11, 6);
        progMem[18] = iType(opSb, 9, 11, 5);
        progMem[19] = iType(opLb, 9, 12, 5);
        progMem[20] = iType(opLb, 9, 13, 4);
        progMem[21] = iType(opLh, 9, 14, 6);
        progMem[22] = iType(opLh, 9, 15, 4);
        progMem[23] = iType(opLw, 9, 16, 4);
        progMem[24] = iType(opLb, 9, 17, 7);
        // Branches over r1 > 0, r2 < 0, r8 == r1
        progMem[25] = iType(opBeq, 1, 8, 1);
        progMem[27] = iType(opBeq, 1, 2, 1);
        progMem[28] = iType(opBne, 1, 2, 1);
        progMem[30] = iType(opBne, 1, 8, 1);
        progMem[31] = iType(opBlez, 2, 0, 1);
        progMem[33] = iType(opBlez, 0, 0, 1);
        progMem[35] = iType(opBlez, 1, 0, 1);
        progMem[36] = iType(opBgtz, 1, 0, 1);
        progMem[38] = iType(opBgtz, 0, 0, 1);
        progMem[39] = iType(opBgtz, 2, 0, 1);
        progMem[40] = jType(opJal, 'h30b0);
        progMem[41] = jType(opJ, 'h30b8);
        progMem[44] = iType(opOri, 0, 18, 'h0055);
        progMem[45] = rType(31, 0, 0, 0, fnJr);
        progMem[46] = iType(opOri, 0, 19, 'h0077);
        progMem[47] = rType(18, 19, 20, 0, fnAddu);
    endtask

    task automatic addRow(input logic [31:0] addr, input logic we, input logic [4:0] rd,
                          input logic [31:0] data);
        expAddr.push_back(addr);
        expWrite.push_back(we);
        expReg.push_back(rd);
        expData.push_back(data);
    endtask

    task automatic loadExpected();
        addRow(32'h0000_3000, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3004, 1'b1, 5'd1,  32'h0000_1234);
        addRow(32'h0000_3008, 1'b1, 5'd2,  32'h8765_0000);
        addRow(32'h0000_300c, 1'b1, 5'd2,  32'h8765_4321);
        addRow(32'h0000_3010, 1'b1, 5'd3,  32'h8765_5555);
        addRow(32'h0000_3014, 1'b1, 5'd4,  32'h8765_30ed);
        addRow(32'h0000_3018, 1'b1, 5'd5,  32'h8765_4101);
        addRow(32'h0000_301c, 1'b1, 5'd6,  32'h8765_5335);
        addRow(32'h0000_3020, 1'b1, 5'd7,  32'h0001_2340);
        addRow(32'h0000_3024, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3028, 1'b1, 5'd8,  32'h0000_1234);
        addRow(32'h0000_302c, 1'b1, 5'd9,  32'h0000_0100);
        addRow(32'h0000_3030, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3034, 1'b1, 5'd10, 32'h8765_4321);
        addRow(32'h0000_3038, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_303c, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3040, 1'b1, 5'd11, 32'h0000_80ff);
        addRow(32'h0000_3044, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3048, 1'b0, 5'd0,  32'h0000_0000);
        // Word at 0x104 now holds 80ffff21
        addRow(32'h0000_304c, 1'b1, 5'd12, 32'hffff_ffff);
        addRow(32'h0000_3050, 1'b1, 5'd13, 32'h0000_0021);
        addRow(32'h0000_3054, 1'b1, 5'd14, 32'hffff_80ff);
        addRow(32'h0000_3058, 1'b1, 5'd15, 32'hffff_ff21);
        addRow(32'h0000_305c, 1'b1, 5'd16, 32'h80ff_ff21);
        addRow(32'h0000_3060, 1'b1, 5'd17, 32'hffff_ff80);
        addRow(32'h0000_3064, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_306c, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3070, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3078, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_307c, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3084, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_308c, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3090, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_3098, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_309c, 1'b0, 5'd0,  32'h0000_0000);
        // jal, subroutine, jr back, then j forward
        addRow(32'h0000_30a0, 1'b1, 5'd31, 32'h0000_30a4);
        addRow(32'h0000_30b0, 1'b1, 5'd18, 32'h0000_0055);
        addRow(32'h0000_30b4, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_30a4, 1'b0, 5'd0,  32'h0000_0000);
        addRow(32'h0000_30b8, 1'b1, 5'd19, 32'h0000_0077);
        addRow(32'h0000_30bc, 1'b1, 5'd20, 32'h0000_00cc);
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s at %0t: got %h, expected %h", name, $time, actual, expected);
        end
    endtask

    // Destination and data only matter when a write is expected
    task automatic checkRow(input int r);
        checkValue("instrAddr", instrAddr, expAddr[r]);
        checkValue("regWrite", {31'b0, regWrite}, {31'b0, expWrite[r]});
        if (expWrite[r]) begin
            checkValue("regAddr", {27'b0, regAddr}, {27'b0, expReg[r]});
            checkValue("regData", regData, expData[r]);
        end
    endtask

    initial begin
        reset = 1'b1;
        loadProgram();
        loadExpected();
        // A register write held on instr during reset must not retire
        instr = progMem[1];
        rowCount = expAddr.size();
        @(posedge clk);
        #(clkPeriod / 4);
        checkValue("instrAddr", instrAddr, resetPc);
        checkValue("regWrite", {31'b0, regWrite}, 32'h0);
        @(posedge clk);
        for (int r = 0; r < rowCount; r++) begin
            @(negedge clk);
            reset = 1'b0;
            instr = fetchWord(instrAddr);
            // Sample halfway to the retiring edge
            #(clkPeriod / 4);
            checkRow(r);
        end
        @(negedge clk);
        $display("Checked %0d instructions, %0d errors", rowCount, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (rowCount > 0);
        #((rowCount + 10) * clkPeriod);
        $display("Timeout: program did not finish within %0d cycles", rowCount + 10);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hdl/mipsPkg.sv
hdl/decodeBus.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/mipsCore.sv
dv/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
# Build the mipsCore testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module mipsCoreTb \
    -Mdir "$OBJ" -o mipsCoreTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$OBJ/mipsCoreTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
